// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tbSdramSubsystem
FILELIST  = compile.f
LOG       = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== ahbSlavePort.sv ====
// AHB-Lite slave port
`timescale 1ns/10ps
`include "sdramTiming_defs.svh"

module ahbSlavePort (
    input  logic              HCLK,
    input  logic              HRESETn,
    input  sdramPkg::ahbAddrT ahb,
    input  logic [31:0]       hwdata,
    output logic [31:0]       hrdata,
    output logic              hready,
    output sdramPkg::memReqT  req,
    input  sdramPkg::memRspT  rsp
);

    logic                   start;
    logic                   dataPhase;   // cycle after the accepted address phase
    logic                   reqValid;
    logic                   pendWrite;
    logic [`SADDR_BITS-1:0] pendSaddr;
    logic [31:0]            pendWdata;

    // NONSEQ and SEQ both have htrans[1] set
    assign start  = hready && ahb.hsel && ahb.htrans[1];
    assign hready = !(dataPhase || reqValid);   // one transfer at a time

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            dataPhase <= 1'b0;
            reqValid  <= 1'b0;
        end else begin
            dataPhase <= start;
            if (dataPhase) begin
                reqValid <= 1'b1;   // write data is in from here on
            end else if (rsp.done) begin
                reqValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (start) begin
            pendWrite <= ahb.hwrite;
            pendSaddr <= ahb.haddr[`SADDR_BITS:1];   // byte lane bit dropped
        end
        if (dataPhase) begin
            pendWdata <= hwdata;
        end
        if (rsp.done && !pendWrite) begin
            hrdata <= rsp.rdata;
        end
    end

    assign req = '{
        valid: reqValid,
        write: pendWrite,
        saddr: pendSaddr,
        wdata: pendWdata
    };

    // request held steady until the sequencer reports it finished
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        req.valid && !rsp.done |=> $stable(req));

endmodule

// ==== compile.f ====
+incdir+.
sdramPkg.sv
ahbSlavePort.sv
portArbiter.sv
sdramSequencer.sv
sdramSubsystem.sv
tbClock.sv
sdramModel.sv
tbSdramSubsystem.sv

// ==== portArbiter.sv ====
// round-robin arbiter for two ports
`timescale 1ns/10ps

module portArbiter (
    input  logic             HCLK,
    input  logic             HRESETn,
    input  sdramPkg::memReqT reqA,
    input  sdramPkg::memReqT reqB,
    output sdramPkg::memRspT rspA,
    output sdramPkg::memRspT rspB,
    output sdramPkg::memReqT req,
    input  sdramPkg::memRspT rsp,
    input  logic             accept
);

    logic locked;   // granted transfer in flight
    logic grantB;   // owner while locked
    logic prioB;    // B wins a tie
    logic selB;

    always_comb begin
        if (locked) begin
            selB = grantB;
        end else if (prioB) begin
            selB = reqB.valid || !reqA.valid;
        end else begin
            selB = reqB.valid && !reqA.valid;
        end
    end

    assign req  = selB ? reqB : reqA;
    assign rspA = '{done: rsp.done && locked && !grantB, rdata: rsp.rdata};
    assign rspB = '{done: rsp.done && locked && grantB, rdata: rsp.rdata};

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            locked <= 1'b0;
            grantB <= 1'b0;
            prioB  <= 1'b0;
        end else if (accept) begin
            locked <= 1'b1;
            grantB <= selB;
        end else if (rsp.done) begin
            locked <= 1'b0;
            prioB  <= !grantB;   // other port first next time
        end
    end

    // sequencer finishes only what was granted
    assert property (@(posedge HCLK) disable iff (!HRESETn) rsp.done |-> locked);

endmodule

// ==== sdramModel.sv ====
// behavioral x16 SDRAM
`timescale 1ns/10ps
`include "sdramTiming_defs.svh"

module sdramModel (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  sdramPkg::sdramPinsT pins,
    output logic [15:0]         dqIn,
    output logic                modeSeen,
    output int                  errors
);

    import sdramPkg::*;

    localparam int REF_LIMIT = `DELAY_TREF + 20;   // a transfer in flight may delay refresh

    logic [15:0]            mem [logic [`SADDR_BITS-1:0]];
    logic [`ROW_BITS-1:0]   openRow [1 << `BA_BITS];
    logic [(1 << `BA_BITS)-1:0] rowOpen;
    int                     nckeCnt;
    int                     refCnt;
    int                     refGap;      // cycles since last refresh
    logic                   ckeUp;
    logic                   preSeen;
    logic                   wrBeat1;
    logic [1:0]             rdStep;
    logic [`SADDR_BITS-1:0] cmdKey;
    logic [`SADDR_BITS-1:0] burstKey;
    logic [`SADDR_BITS-1:0] burstKey2;   // second beat of the pair

    assign cmdKey    = {pins.ba, openRow[pins.ba], pins.addr[`COL_BITS-1:0]};
    assign burstKey2 = {burstKey[`SADDR_BITS-1:1], !burstKey[0]};

    // never-written words read back as a pattern of their address
    function automatic logic [15:0] readBeat(input logic [`SADDR_BITS-1:0] key);
        if (mem.exists(key)) begin
            return mem[key];
        end
        return 16'(key ^ (key >> 11));
    endfunction

    initial begin
        errors = 0;
        dqIn   = '0;
    end

    always @(posedge HCLK) begin
        if (!HRESETn) begin
            rowOpen  <= '0;
            nckeCnt  <= 0;
            refCnt   <= 0;
            refGap   <= 0;
            ckeUp    <= 1'b0;
            preSeen  <= 1'b0;
            modeSeen <= 1'b0;
            wrBeat1  <= 1'b0;
            rdStep   <= '0;
            dqIn     <= '0;
        end else begin
            if (pins.cmd == NOP_NCKE) begin
                nckeCnt <= nckeCnt + 1;
            end else begin
                ckeUp <= 1'b1;
            end
            if (refCnt > 0) begin
                refGap <= refGap + 1;
            end
            case (pins.cmd)
                PRECHARGE_ALL: begin
                    rowOpen <= '0;
                    preSeen <= 1'b1;
                end
                AUTO_REFRESH: begin
                    refCnt <= refCnt + 1;
                    refGap <= 0;
                end
                LOAD_MODE: modeSeen <= 1'b1;
                ACTIVE: begin
                    rowOpen[pins.ba] <= 1'b1;
                    openRow[pins.ba] <= pins.addr;
                end
                READ, WRITE: begin
                    rowOpen[pins.ba] <= !pins.addr[10];   // A10 closes the bank
                    burstKey         <= cmdKey;
                end
                default: ;
            endcase
            if (pins.cmd == WRITE && pins.dqOe) begin
                mem[cmdKey] = pins.dqOut;
            end
            if (wrBeat1 && pins.dqOe) begin
                mem[burstKey2] = pins.dqOut;
            end
            wrBeat1 <= (pins.cmd == WRITE);
            // CAS 2: beats on the bus two and three cycles after READ
            rdStep <= (pins.cmd == READ) ? 2'd1 : (rdStep == 2'd1) ? 2'd2 : 2'd0;
            if (rdStep == 2'd1) begin
                dqIn <= readBeat(burstKey);
            end
            if (rdStep == 2'd2) begin
                dqIn <= readBeat(burstKey2);
            end
        end
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd != NOP_NCKE && !ckeUp |-> nckeCnt >= `DELAY_NCKE)
    else begin
        errors++;
        $display("CKE went high after only %0d cycles", $sampled(nckeCnt));
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd == PRECHARGE_ALL |-> pins.addr[10])
    else begin
        errors++;
        $display("precharge issued without A10 set at %0t ns", $time);
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd == LOAD_MODE |-> preSeen && refCnt >= `INIT_AUTO_REFS)
    else begin
        errors++;
        $display("mode register loaded before precharge and init refreshes");
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd == LOAD_MODE |-> pins.addr == `ROW_BITS'(`MODE_WORD))
    else begin
        errors++;
        $display("** Error at %0t ns: sdram.addr expected %h, got %h", $time,
            `ROW_BITS'(`MODE_WORD), $sampled(pins.addr));
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd == ACTIVE |-> modeSeen && !rowOpen[pins.ba])
    else begin
        errors++;
        $display("ACTIVE before mode load or to an open bank at %0t ns", $time);
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd == READ || pins.cmd == WRITE |-> rowOpen[pins.ba] && pins.addr[10])
    else begin
        errors++;
        $display("READ or WRITE to a closed bank or without auto-precharge at %0t ns", $time);
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        refCnt > 0 |-> refGap <= REF_LIMIT)
    else begin
        errors++;
        $display("no auto-refresh for %0d cycles", $sampled(refGap));
    end

endmodule

// ==== sdramPkg.sv ====
// SDRAM subsystem types
`include "sdramTiming_defs.svh"

package sdramPkg;

    // pin pattern {CKE, CSn, RASn, CASn, WEn}
    typedef enum logic [4:0] {
        NOP_NCKE      = 5'b00111,
        NOP           = 5'b10111,
        PRECHARGE_ALL = 5'b10010,
        AUTO_REFRESH  = 5'b10001,
        LOAD_MODE     = 5'b10000,
        ACTIVE        = 5'b10011,
        READ          = 5'b10101,
        WRITE         = 5'b10100
    } sdramCmdT;

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`SADDR_BITS-1:0]  saddr;   // halfword address
        logic [31:0]             wdata;
    } memReqT;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } memRspT;

    typedef struct packed {
        sdramCmdT              cmd;
        logic [`ROW_BITS-1:0]  addr;
        logic [`BA_BITS-1:0]   ba;
        logic [15:0]           dqOut;
        logic                  dqOe;
    } sdramPinsT;

    // AHB-Lite address phase
    typedef struct packed {
        logic        hsel;
        logic [1:0]  htrans;
        logic        hwrite;
        logic [2:0]  hsize;
        logic [31:0] haddr;
    } ahbAddrT;

endpackage

// ==== sdramSequencer.sv ====
// SDRAM command sequencer
`timescale 1ns/10ps
`include "sdramTiming_defs.svh"

module sdramSequencer (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  sdramPkg::memReqT    req,
    output logic                accept,
    output sdramPkg::memRspT    rsp,
    output sdramPkg::sdramPinsT pins,
    input  logic [15:0]         dqIn
);

    import sdramPkg::*;

    typedef enum logic [4:0] {
        stInitNcke, stInitCke, stInitPre, stInitPreWait,
        stInitRef, stInitRefWait, stInitLmr, stInitLmrWait,
        stIdle, stAct, stActWait,
        stRead, stCasWait, stRd0, stRd1, stReadWait,
        stWr0, stWr1, stWriteWait,
        stRef, stRefWait
    } stateT;

    stateT                  state;
    stateT                  next;
    logic [3:0]             shortCnt;
    logic [15:0]            longCnt;      // CKE hold, then refresh interval
    logic [2:0]             repCnt;       // init refreshes left
    logic                   modeLoaded;
    logic                   shortDone;
    logic                   longDone;
    logic                   curWrite;
    logic [`SADDR_BITS-1:0] curSaddr;
    logic [31:0]            curWdata;
    logic [31:0]            rdata;
    logic [`BA_BITS-1:0]    bank;
    logic [`ROW_BITS-1:0]   row;
    logic [`COL_BITS-1:0]   col;

    assign shortDone = (shortCnt == '0);
    assign longDone  = (longCnt == '0);   // refresh due once out of init
    assign accept    = (state == stIdle) && !longDone && req.valid;
    assign {bank, row, col} = curSaddr;

    always_comb begin
        next = state;
        case (state)
            stInitNcke:    next = longDone ? stInitCke : stInitNcke;
            stInitCke:     next = stInitPre;
            stInitPre:     next = stInitPreWait;
            stInitPreWait: next = shortDone ? stInitRef : stInitPreWait;
            stInitRef:     next = stInitRefWait;
            stInitRefWait: begin
                if (shortDone) begin
                    next = (repCnt == '0) ? stInitLmr : stInitRef;
                end
            end
            stInitLmr:     next = stInitLmrWait;
            stInitLmrWait: next = shortDone ? stIdle : stInitLmrWait;
            stIdle: begin
                if (longDone) begin
                    next = stRef;   // refresh beats a waiting request
                end else if (req.valid) begin
                    next = stAct;
                end
            end
            stAct:         next = stActWait;
            stActWait: begin
                if (shortDone) begin
                    next = curWrite ? stWr0 : stRead;
                end
            end
            stRead:        next = stCasWait;
            stCasWait:     next = stRd0;
            stRd0:         next = stRd1;
            stRd1:         next = stReadWait;
            stReadWait:    next = shortDone ? stIdle : stReadWait;
            stWr0:         next = stWr1;
            stWr1:         next = stWriteWait;
            stWriteWait:   next = shortDone ? stIdle : stWriteWait;
            stRef:         next = stRefWait;
            stRefWait:     next = shortDone ? stIdle : stRefWait;
            default:       next = stInitNcke;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            state      <= stInitNcke;
            shortCnt   <= '0;
            longCnt    <= 16'(`DELAY_NCKE);
            repCnt     <= 3'(`INIT_AUTO_REFS);
            modeLoaded <= 1'b0;
        end else begin
            state <= next;
            case (state)
                stInitPre:        shortCnt <= 4'(`DELAY_TRP);
                stInitRef, stRef: shortCnt <= 4'(`DELAY_TRFC);
                stInitLmr:        shortCnt <= 4'(`DELAY_TMRD);
                stAct:            shortCnt <= 4'(`DELAY_TRCD);
                stRd1:            shortCnt <= 4'(`DELAY_AFTER_READ);
                stWr1:            shortCnt <= 4'(`DELAY_AFTER_WRITE);
                default: begin
                    if (!shortDone) begin
                        shortCnt <= shortCnt - 1'b1;
                    end
                end
            endcase
            if (state == stInitRef || state == stRef) begin
                longCnt <= 16'(`DELAY_TREF);
            end else if (!longDone) begin
                longCnt <= longCnt - 1'b1;
            end
            if (state == stInitRef) begin
                repCnt <= repCnt - 1'b1;
            end
            if (state == stInitLmr) begin
                modeLoaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            curWrite <= req.write;
            curSaddr <= req.saddr;
            curWdata <= req.wdata;
        end
        if (state == stRd0) begin
            rdata[15:0] <= dqIn;    // low half arrives first
        end
        if (state == stRd1) begin
            rdata[31:16] <= dqIn;
        end
    end

    assign rsp = '{
        done:  (state == stReadWait || state == stWriteWait) && shortDone,
        rdata: rdata
    };

    always_comb begin
        pins.cmd   = NOP;
        pins.addr  = '0;
        pins.ba    = '0;
        pins.dqOut = '0;
        pins.dqOe  = 1'b0;
        case (state)
            stInitNcke: pins.cmd = NOP_NCKE;
            stInitPre: begin
                pins.cmd      = PRECHARGE_ALL;
                pins.addr[10] = 1'b1;   // all banks
            end
            stInitRef, stRef: pins.cmd = AUTO_REFRESH;
            stInitLmr: begin
                pins.cmd  = LOAD_MODE;
                pins.addr = `ROW_BITS'(`MODE_WORD);
            end
            stAct: begin
                pins.cmd  = ACTIVE;
                pins.addr = row;
                pins.ba   = bank;
            end
            stRead, stWr0: begin
                pins.cmd                  = (state == stWr0) ? WRITE : READ;
                pins.addr[`COL_BITS-1:0]  = col;
                pins.addr[10]             = 1'b1;   // auto-precharge
                pins.ba                   = bank;
                pins.dqOut                = curWdata[15:0];
                pins.dqOe                 = (state == stWr0);
            end
            stWr1: begin
                pins.dqOut = curWdata[31:16];
                pins.dqOe  = 1'b1;
            end
            default: ;
        endcase
    end

    // a row is only opened once init has programmed the mode register
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        pins.cmd == ACTIVE |-> modeLoaded);

endmodule

// ==== sdramSubsystem.sv ====
// two-port SDRAM subsystem top
`timescale 1ns/10ps

module sdramSubsystem (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  sdramPkg::ahbAddrT   cpuAhb,
    input  sdramPkg::ahbAddrT   dmaAhb,
    input  logic [31:0]         cpuHwdata,
    input  logic [31:0]         dmaHwdata,
    output logic [31:0]         cpuHrdata,
    output logic [31:0]         dmaHrdata,
    output logic                cpuHready,
    output logic                dmaHready,
    output sdramPkg::sdramPinsT sdram,
    input  logic [15:0]         dqIn
);

    import sdramPkg::*;

    memReqT cpuReq;
    memReqT dmaReq;
    memReqT seqReq;   // granted request
    memRspT cpuRsp;
    memRspT dmaRsp;
    memRspT seqRsp;
    logic   accept;

    ahbSlavePort iCpuPort (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .ahb(cpuAhb), .hwdata(cpuHwdata), .hrdata(cpuHrdata), .hready(cpuHready),
        .req(cpuReq), .rsp(cpuRsp)
    );

    ahbSlavePort iDmaPort (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .ahb(dmaAhb), .hwdata(dmaHwdata), .hrdata(dmaHrdata), .hready(dmaHready),
        .req(dmaReq), .rsp(dmaRsp)
    );

    portArbiter iArbiter (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .reqA(cpuReq), .reqB(dmaReq), .rspA(cpuRsp), .rspB(dmaRsp),
        .req(seqReq), .rsp(seqRsp), .accept(accept)
    );

    sdramSequencer iSequencer (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .req(seqReq), .accept(accept), .rsp(seqRsp),
        .pins(sdram), .dqIn(dqIn)
    );

endmodule

// ==== sdramTiming_defs.svh ====
// SDRAM geometry and timing
`ifndef SDRAM_TIMING_DEFS_SVH
`define SDRAM_TIMING_DEFS_SVH

// saddr is {bank, row, column}
`define COL_BITS    9
`define ROW_BITS    11
`define BA_BITS     2
`define SADDR_BITS  (`BA_BITS + `ROW_BITS + `COL_BITS)

// cycle counts, shortened for simulation
`define DELAY_NCKE         20   // CKE low hold at power-up
`define DELAY_TREF         300  // refresh interval
`define DELAY_TRP          1
`define DELAY_TRFC         7
`define DELAY_TMRD         0
`define DELAY_TRCD         1
`define DELAY_AFTER_READ   3    // covers tRC with auto-precharge
`define DELAY_AFTER_WRITE  5

`define INIT_AUTO_REFS     2

// CAS 2, sequential, burst length 2
`define MODE_WORD          'h021

`endif

// ==== tbClock.sv ====
// testbench clock and reset
`timescale 1ns/10ps

module tbClock (
    output logic HCLK,
    output logic HRESETn
);

    initial begin
        HCLK = 1'b0;
        forever #4 HCLK = ~HCLK;   // 8 ns period
    end

    initial begin
        HRESETn = 1'b0;
        repeat (4) @(posedge HCLK);
        HRESETn <= 1'b1;
    end

endmodule

// ==== tbSdramSubsystem.sv ====
// SDRAM subsystem testbench
`timescale 1ns/10ps
`include "sdramTiming_defs.svh"

module tbSdramSubsystem;

    import sdramPkg::*;

    localparam int XFERS      = 40;
    localparam int MAX_CYCLES = XFERS * 30 + `DELAY_NCKE + 60
                              + (XFERS * 30 / `DELAY_TREF + 1) * 10;
    localparam int RAND_BITS  = `SADDR_BITS - 2;
    localparam int ROW_LSB    = `COL_BITS;
    localparam int BA_LSB     = `SADDR_BITS - `BA_BITS;

    logic                   HCLK;
    logic                   HRESETn;
    ahbAddrT                cpuAhb;
    ahbAddrT                dmaAhb;
    logic [31:0]            cpuHwdata;
    logic [31:0]            dmaHwdata;
    logic [31:0]            cpuHrdata;
    logic [31:0]            dmaHrdata;
    logic                   cpuHready;
    logic                   dmaHready;
    sdramPinsT              sdram;
    logic [15:0]            dqIn;
    logic                   modeSeen;
    int                     modelErrors;
    int                     errors;
    int                     cycles;
    logic [15:0]            lfsr;
    logic [1:0]             busy;         // port 0 is the CPU, port 1 the DMA
    logic [1:0]             rdPend;
    logic [`SADDR_BITS-1:0] curSaddr [2];
    logic [31:0]            expData [2];
    logic [31:0]            refMem [logic [`SADDR_BITS-1:0]];
    logic [`SADDR_BITS-1:0] addrList [2][10];
    logic [31:0]            dataList [2][10];
    logic                   contend;
    logic                   lastBa1;

    tbClock iClock (.HCLK(HCLK), .HRESETn(HRESETn));

    sdramSubsystem i_dut (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .cpuAhb(cpuAhb), .dmaAhb(dmaAhb),
        .cpuHwdata(cpuHwdata), .dmaHwdata(dmaHwdata),
        .cpuHrdata(cpuHrdata), .dmaHrdata(dmaHrdata),
        .cpuHready(cpuHready), .dmaHready(dmaHready),
        .sdram(sdram), .dqIn(dqIn)
    );

    sdramModel iModel (
        .HCLK(HCLK), .HRESETn(HRESETn), .pins(sdram), .dqIn(dqIn),
        .modeSeen(modeSeen), .errors(modelErrors)
    );

    // Galois LFSR, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // bank msb picks the port's region, word aligned
    function automatic logic [`SADDR_BITS-1:0] newSaddr(input logic region);
        logic [RAND_BITS-1:0] r;
        r = RAND_BITS'(takeBits(RAND_BITS));
        return {region, r, 1'b0};
    endfunction

    task automatic ahbXfer(input logic p, input logic write,
                           input logic [`SADDR_BITS-1:0] saddr, input logic [31:0] wdata);
        ahbAddrT addrPhase;
        addrPhase = '{hsel: 1'b1, htrans: 2'b10, hwrite: write, hsize: 3'b010,
                      haddr: {{(31 - `SADDR_BITS){1'b0}}, saddr, 1'b0}};
        @(posedge HCLK);
        if (p) begin
            dmaAhb <= addrPhase;
        end else begin
            cpuAhb <= addrPhase;
        end
        busy[p]     = 1'b1;
        rdPend[p]   = !write;
        curSaddr[p] = saddr;
        if (!write) begin
            expData[p] = refMem[saddr];
        end
        @(posedge HCLK);
        if (p) begin
            dmaAhb    <= '0;
            dmaHwdata <= wdata;
        end else begin
            cpuAhb    <= '0;
            cpuHwdata <= wdata;
        end
        do @(posedge HCLK); while (!(p ? dmaHready : cpuHready));
        busy[p]   = 1'b0;
        rdPend[p] = 1'b0;
        if (write) begin
            refMem[saddr] = wdata;
        end
    endtask

    task automatic runPort(input logic p);
        for (int k = 0; k < 4; k++) begin
            ahbXfer(p, 1'b1, addrList[p][k], dataList[p][k]);
        end
        for (int k = 0; k < 4; k++) begin
            ahbXfer(p, 1'b0, addrList[p][k], '0);
        end
    endtask

    always @(posedge HCLK) begin
        if (sdram.cmd == ACTIVE) begin
            lastBa1 <= sdram.ba[1];
        end
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(cpuHready) && rdPend[0] |-> cpuHrdata == expData[0])
    else begin
        errors++;
        $display("** Error at %0t ns: cpuHrdata expected %h, got %h", $time,
            $sampled(expData[0]), $sampled(cpuHrdata));
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(dmaHready) && rdPend[1] |-> dmaHrdata == expData[1])
    else begin
        errors++;
        $display("** Error at %0t ns: dmaHrdata expected %h, got %h", $time,
            $sampled(expData[1]), $sampled(dmaHrdata));
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(cpuHready) || $rose(dmaHready) |-> modeSeen)
    else begin
        errors++;
        $display("a transfer finished before SDRAM init was complete");
    end

    // ACTIVE opens the bank and row of an open transfer
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        sdram.cmd == ACTIVE |->
            (busy[0] && {sdram.ba, sdram.addr} == curSaddr[0][`SADDR_BITS-1:ROW_LSB]) ||
            (busy[1] && {sdram.ba, sdram.addr} == curSaddr[1][`SADDR_BITS-1:ROW_LSB]))
    else begin
        errors++;
        $display("** Error at %0t ns: sdram ba/addr expected %h or %h, got %h", $time,
            $sampled(curSaddr[0][`SADDR_BITS-1:ROW_LSB]),
            $sampled(curSaddr[1][`SADDR_BITS-1:ROW_LSB]), $sampled({sdram.ba, sdram.addr}));
    end

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        sdram.cmd == READ || sdram.cmd == WRITE |-> sdram.addr[10] &&
            ((busy[0] && sdram.ba == curSaddr[0][`SADDR_BITS-1:BA_LSB] &&
              sdram.addr[`COL_BITS-1:0] == curSaddr[0][`COL_BITS-1:0]) ||
             (busy[1] && sdram.ba == curSaddr[1][`SADDR_BITS-1:BA_LSB] &&
              sdram.addr[`COL_BITS-1:0] == curSaddr[1][`COL_BITS-1:0])))
    else begin
        errors++;
        $display("** Error at %0t ns: sdram.addr column expected %h or %h, got %h", $time,
            $sampled(curSaddr[0][`COL_BITS-1:0]), $sampled(curSaddr[1][`COL_BITS-1:0]),
            $sampled(sdram.addr));
    end

    // both ports waiting, so rows open in turn
    // the first tie goes to the DMA, since the CPU had the last grant
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        sdram.cmd == ACTIVE && contend |-> sdram.ba[1] != lastBa1)
    else begin
        errors++;
        $display("one port got two grants in a row while the other was waiting");
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge HCLK);
            cycles++;
        end
        $display("timeout after %0d cycles, a transfer never finished", cycles);
        $display("errors: %0d testbench, %0d model", errors, modelErrors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        cpuAhb    = '0;
        dmaAhb    = '0;
        cpuHwdata = '0;
        dmaHwdata = '0;
        busy      = '0;
        rdPend    = '0;
        contend   = 1'b0;
        lastBa1   = 1'b0;
        errors    = 0;
        lfsr      = 16'd47;
        @(posedge HRESETn);
        ahbXfer(1'b0, 1'b1, newSaddr(1'b0), takeBits(32));   // lands during init
        for (int k = 0; k < 10; k++) begin
            addrList[0][k] = newSaddr(1'b0);
            ahbXfer(1'b0, 1'b1, addrList[0][k], takeBits(32));
        end
        for (int k = 0; k < 10; k++) begin
            ahbXfer(1'b0, 1'b0, addrList[0][k], '0);
        end
        for (int k = 0; k < 4; k++) begin
            addrList[0][k] = newSaddr(1'b0);
            addrList[1][k] = newSaddr(1'b1);
            dataList[0][k] = takeBits(32);
            dataList[1][k] = takeBits(32);
        end
        contend = 1'b1;
        fork
            runPort(1'b0);
            runPort(1'b1);
        join
        contend = 1'b0;
        @(posedge HCLK);
        $display("errors: %0d testbench, %0d model", errors, modelErrors);
        if (errors == 0 && modelErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
